// File: flist.f
source/cyclic_bram_pkg.sv
source/bram_if.sv
source/cyclic_addr_ctrl.sv
source/bram_sdp.sv
source/n_delay.sv
source/sync_fifo.sv
source/cyclic_bram.sv
test/cyclic_bram_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the cyclic_bram testbench with Verilator.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -j 0 \
  --top-module cyclic_bram_tb \
  -f flist.f \
  -o cyclic_bram_sim

# the log keeps the run output for the search below.
./obj_dir/cyclic_bram_sim | tee sim.log

if grep -q "Done: errors found" sim.log; then
  echo "simulation reported failure"
  exit 1
fi

echo "simulation passed"
exit 0

// File: source/bram_if.sv
// interface bram_if: RAM write and read ports, with ctrl and mem modports.

interface bram_if
  import cyclic_bram_pkg::*;
();

  // write port.
  logic  wr_en;
  addr_t wr_addr;
  word_t wr_data;

  // read port.
  logic  rd_en;
  addr_t rd_addr;
  word_t rd_data;

  // address controller side.
  modport ctrl (
    output wr_en,
    output wr_addr,
    output wr_data,
    output rd_en,
    output rd_addr,
    input  rd_data
  );

  // memory side.
  modport mem (
    input  wr_en,
    input  wr_addr,
    input  wr_data,
    input  rd_en,
    input  rd_addr,
    output rd_data
  );

endinterface

// File: source/bram_sdp.sv
// module bram_sdp: simple dual-port RAM with a LATENCY-stage pipelined read output.

module bram_sdp
  import cyclic_bram_pkg::*;
#(
  parameter int DEPTH   = DEPTH_DEFAULT,
  parameter int LATENCY = LATENCY_DEFAULT
) (
  input  logic clk,
  input  logic arst_n,
  input  logic clken,
  bram_if.mem  bram
);

  // index bits actually needed for the array.
  localparam int IDX_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  word_t mem [DEPTH];

  // read output chain, stage 0 is loaded from the array.
  word_t [LATENCY-1:0] pipe;

  // synchronous write, the enable already carries clken.
  always_ff @(posedge clk) begin
    if (bram.wr_en) begin
      mem[bram.wr_addr[IDX_W-1:0]] <= bram.wr_data;
    end
  end

  // the chain only moves while clken is high.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pipe <= '0;
    end else if (clken) begin
      for (int i = LATENCY - 1; i > 0; i--) begin
        pipe[i] <= pipe[i-1];
      end
      // stage 0 holds when nothing is requested.
      if (bram.rd_en) begin
        pipe[0] <= mem[bram.rd_addr[IDX_W-1:0]];
      end
    end
  end

  assign bram.rd_data = pipe[LATENCY-1];

endmodule

// File: source/cyclic_addr_ctrl.sv
// module cyclic_addr_ctrl: cyclic write and read address counters driving the RAM ports.

module cyclic_addr_ctrl
  import cyclic_bram_pkg::*;
#(
  parameter int DEPTH = DEPTH_DEFAULT
) (
  input  logic  clk,
  input  logic  arst_n,
  input  logic  clken,
  input  logic  w_en,
  input  logic  r_en,
  input  word_t s_data,
  input  addr_t w_addr_max,
  input  addr_t r_addr_min,
  input  addr_t r_addr_max,
  bram_if.ctrl  bram
);

  // highest address that exists in the array.
  localparam addr_t LAST_ADDR = addr_t'(DEPTH - 1);

  addr_t w_addr;
  addr_t w_addr_next;
  addr_t r_addr;
  addr_t r_addr_next;
  logic  w_last;
  logic  r_last;
  logic  w_fire;
  logic  r_fire;

  // accesses only count while the block is enabled.
  assign w_fire = clken & w_en;
  assign r_fire = clken & r_en;

  // write side wraps to zero at the programmed max.
  // the array end also forces a wrap, so a bad max cannot run off the RAM.
  assign w_last      = (w_addr == w_addr_max) || (w_addr == LAST_ADDR);
  assign w_addr_next = w_last ? '0 : w_addr + 1'b1;

  // read side wraps back to the programmed min.
  assign r_last      = (r_addr == r_addr_max) || (r_addr == LAST_ADDR);
  assign r_addr_next = r_last ? r_addr_min : r_addr + 1'b1;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      w_addr <= '0;
    end else if (w_fire) begin
      w_addr <= w_addr_next;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      r_addr <= '0;
    end else if (r_fire) begin
      r_addr <= r_addr_next;
    end
  end

  // RAM write port.
  assign bram.wr_en   = w_fire;
  assign bram.wr_addr = w_addr;
  assign bram.wr_data = s_data;

  // RAM read port, the current address is the one read this cycle.
  assign bram.rd_en   = r_fire;
  assign bram.rd_addr = r_addr;

endmodule

// File: source/cyclic_bram.sv
// module cyclic_bram: cyclic weight buffer top with address control, RAM, delay line and FIFO.

module cyclic_bram
  import cyclic_bram_pkg::*;
#(
  parameter int DEPTH   = DEPTH_DEFAULT,
  parameter int LATENCY = LATENCY_DEFAULT
) (
  input  logic  clk,
  input  logic  arst_n,
  input  logic  clken,
  input  logic  w_en,
  input  logic  r_en,
  input  word_t s_data,
  input  addr_t w_addr_max,
  input  addr_t r_addr_min,
  input  addr_t r_addr_max,
  output word_t m_data,
  output logic  m_valid,
  output logic  fifo_empty
);

  bram_if bram_bus ();

  logic rd_req;
  logic rd_back;
  logic fifo_pop;
  logic empty;

  // a read is only issued on an enabled edge.
  assign rd_req = clken & r_en;

  cyclic_addr_ctrl #(
    .DEPTH (DEPTH)
  ) i_ctrl (
    .clk        (clk),
    .arst_n     (arst_n),
    .clken      (clken),
    .w_en       (w_en),
    .r_en       (r_en),
    .s_data     (s_data),
    .w_addr_max (w_addr_max),
    .r_addr_min (r_addr_min),
    .r_addr_max (r_addr_max),
    .bram       (bram_bus.ctrl)
  );

  bram_sdp #(
    .DEPTH   (DEPTH),
    .LATENCY (LATENCY)
  ) i_bram (
    .clk    (clk),
    .arst_n (arst_n),
    .clken  (clken),
    .bram   (bram_bus.mem)
  );

  // follows each request down the RAM pipeline.
  n_delay #(
    .N (LATENCY)
  ) i_req_delay (
    .clk      (clk),
    .arst_n   (arst_n),
    .clken    (clken),
    .data_in  (rd_req),
    .data_out (rd_back)
  );

  // reader consumes the head whenever it asks and a word is there.
  assign fifo_pop = clken & r_en & ~empty;

  // one spare slot beyond the words in flight.
  sync_fifo #(
    .DEPTH (LATENCY + 1)
  ) i_fifo (
    .clk    (clk),
    .arst_n (arst_n),
    .clken  (clken),
    .push   (rd_back),
    .pop    (fifo_pop),
    .din    (bram_bus.rd_data),
    .dout   (m_data),
    .empty  (empty),
    .full   ()
  );

  assign m_valid    = ~empty;
  assign fifo_empty = empty;

endmodule

// File: source/cyclic_bram_pkg.sv
// package cyclic_bram_pkg: weight word and RAM address types, default buffer sizes.

package cyclic_bram_pkg;

  // one weight word as it is stored and streamed.
  typedef logic [7:0] word_t;

  // address width, enough for up to 1024 words.
  localparam int ADDR_W = 10;

  // word address into the weight RAM.
  typedef logic [ADDR_W-1:0] addr_t;

  // default RAM depth in words.
  localparam int DEPTH_DEFAULT = 16;

  // default read latency of the RAM in cycles.
  localparam int LATENCY_DEFAULT = 3;

endpackage

// File: source/n_delay.sv
// module n_delay: clock-enabled N-stage shift chain for read request bits.

module n_delay #(
  parameter int N = 3
) (
  input  logic clk,
  input  logic arst_n,
  input  logic clken,
  input  logic data_in,
  output logic data_out
);

  logic [N-1:0] chain;

  // shifts one stage per enabled edge, matching the RAM read pipeline.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      chain <= '0;
    end else if (clken) begin
      chain[0] <= data_in;
      for (int i = 1; i < N; i++) begin
        chain[i] <= chain[i-1];
      end
    end
  end

  // high in the cycle the RAM output holds the requested word.
  assign data_out = chain[N-1];

endmodule

// File: source/sync_fifo.sv
// module sync_fifo: first-word-fall-through FIFO with occupancy count, empty and full flags.

module sync_fifo
  import cyclic_bram_pkg::*;
#(
  parameter int DEPTH = LATENCY_DEFAULT + 1
) (
  input  logic  clk,
  input  logic  arst_n,
  input  logic  clken,
  input  logic  push,
  input  logic  pop,
  input  word_t din,
  output word_t dout,
  output logic  empty,
  output logic  full
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);
  localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(DEPTH - 1);

  word_t            mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_push;
  logic             do_pop;

  // pointer step with wrap, DEPTH need not be a power of two.
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_LAST) ? '0 : ptr + 1'b1;
  endfunction

  assign empty = (count == '0);
  assign full  = (count == CNT_W'(DEPTH));

  // a full FIFO can still take a word when the head leaves on the same edge.
  assign do_pop  = clken & pop & ~empty;
  assign do_push = clken & push & (~full | do_pop);

  // head is always on the output.
  assign dout = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= din;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (do_pop) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      // occupancy only changes when exactly one side moves.
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// File: test/cyclic_bram_tb.sv
// module cyclic_bram_tb: directed tests, scoreboard model and timeout for the cyclic weight buffer.

module cyclic_bram_tb
  import cyclic_bram_pkg::*;
;

  localparam int DEPTH   = 16;
  localparam int LATENCY = 3;

  // tests take about 450 cycles, random stalls included, so this leaves wide margin.
  localparam int MAX_CYCLES = 4000;

  logic  clk = 1'b0;
  logic  arst_n;
  logic  clken;
  logic  w_en;
  logic  r_en;
  word_t s_data;
  addr_t w_addr_max;
  addr_t r_addr_min;
  addr_t r_addr_max;
  word_t m_data;
  logic  m_valid;
  logic  fifo_empty;

  integer seed = 63804;
  int     cycle_count = 0;
  int     req_count = 0;
  string  test_name = "init";

  // reference model of the RAM contents and both address counters.
  word_t  model_mem [1 << ADDR_W];
  addr_t  wr_addr_model = '0;
  addr_t  rd_addr_model = '0;
  word_t  exp_q [$];
  word_t  exp_word;

  // requests on their way to the FIFO head, one bit per enabled edge.
  logic [LATENCY:0] flight_model = '0;
  int               occ_model = 0;
  logic             exp_valid;

  cyclic_bram #(
    .DEPTH   (DEPTH),
    .LATENCY (LATENCY)
  ) i_dut (
    .clk        (clk),
    .arst_n     (arst_n),
    .clken      (clken),
    .w_en       (w_en),
    .r_en       (r_en),
    .s_data     (s_data),
    .w_addr_max (w_addr_max),
    .r_addr_min (r_addr_min),
    .r_addr_max (r_addr_max),
    .m_data     (m_data),
    .m_valid    (m_valid),
    .fifo_empty (fifo_empty)
  );

  always #4 clk = ~clk;

  task automatic stop_on_error();
    $display("Done: errors found");
    $fatal(1);
  endtask

  task automatic check_equal(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("Fail %s: expected %0h, actual %0h", name, expected, actual);
      stop_on_error();
    end
  endtask

  function automatic logic random_bit();
    int r;
    r = $random(seed);
    return r[0];
  endfunction

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= MAX_CYCLES) begin
      $display("timeout: tests still running after %0d cycles", cycle_count);
      stop_on_error();
    end
  end

  // inputs are stable at the falling edge and hold the values of the coming edge.
  always @(negedge clk) begin
    if (arst_n) begin
      // a word reaches the head LATENCY+1 enabled edges after its request.
      exp_valid = (occ_model != 0);
      check_equal(test_name, 32'(exp_valid), 32'(m_valid));
      check_equal(test_name, 32'(!exp_valid), 32'(fifo_empty));
      // head leaves on the coming edge, compared in request order.
      if (clken && r_en && exp_valid) begin
        exp_word = exp_q.pop_front();
        check_equal(test_name, 32'(exp_word), 32'(m_data));
      end
      if (clken) begin
        flight_model = {flight_model[LATENCY-1:0], r_en};
        if (r_en && exp_valid) begin
          occ_model--;
        end
        if (flight_model[LATENCY]) begin
          occ_model++;
        end
      end
      if (clken && w_en) begin
        model_mem[wr_addr_model] = s_data;
        wr_addr_model = (wr_addr_model == w_addr_max) ? '0 : wr_addr_model + addr_t'(1);
      end
      if (clken && r_en) begin
        exp_q.push_back(model_mem[rd_addr_model]);
        rd_addr_model = (rd_addr_model == r_addr_max) ? r_addr_min
                                                      : rd_addr_model + addr_t'(1);
        req_count++;
      end
    end
  end

  task automatic write_words(input int first, input int n);
    for (int i = 0; i < n; i++) begin
      w_en   <= 1'b1;
      s_data <= word_t'(first + i);
      @(posedge clk);
    end
    w_en <= 1'b0;
  endtask

  // issues exactly n accepted reads.
  task automatic read_words(input int n);
    int target;
    target = req_count + n;
    r_en <= 1'b1;
    while (req_count < target) begin
      @(posedge clk);
    end
    r_en <= 1'b0;
  endtask

  task automatic check_reset_state();
    test_name = "reset_state";
    @(negedge clk);
    check_equal(test_name, 32'd0, 32'(m_valid));
    check_equal(test_name, 32'd1, 32'(fifo_empty));
    @(posedge clk);
  endtask

  // distinct words make the address order visible in the stream.
  task automatic fill_and_stream();
    test_name = "fill_stream";
    write_words(8'hA0, DEPTH);
    read_words(40);
  endtask

  task automatic narrow_read_window();
    test_name = "read_window";
    r_addr_min <= 10'd4;
    r_addr_max <= 10'd9;
    read_words(20);
  endtask

  // w_en only rises while the block is stalled, so no write may land.
  task automatic stall_during_read(input int n);
    int   target;
    logic en;
    test_name = "clken_stall";
    s_data <= 8'hEE;
    target = req_count + n;
    r_en <= 1'b1;
    while (req_count < target) begin
      en = random_bit();
      clken <= en;
      w_en  <= !en;
      @(posedge clk);
    end
    r_en  <= 1'b0;
    w_en  <= 1'b0;
    clken <= 1'b1;
  endtask

  task automatic random_read_enable(input int cycles);
    test_name = "random_r_en";
    for (int i = 0; i < cycles; i++) begin
      r_en <= random_bit();
      @(posedge clk);
    end
    r_en <= 1'b0;
  endtask

  task automatic write_wrap_overwrite();
    test_name = "write_wrap";
    w_addr_max <= 10'd7;
    write_words(8'h50, 12);
    // walk the read address round to 0 before the window shrinks to 0..7.
    r_addr_min <= '0;
    r_addr_max <= 10'd9;
    r_en <= 1'b1;
    do begin
      @(posedge clk);
    end while (rd_addr_model != '0);
    r_en <= 1'b0;
    r_addr_max <= 10'd7;
    read_words(16);
  endtask

  initial begin
    arst_n     = 1'b0;
    clken      = 1'b0;
    w_en       = 1'b0;
    r_en       = 1'b0;
    s_data     = '0;
    w_addr_max = 10'd15;
    r_addr_min = '0;
    r_addr_max = 10'd15;
    repeat (5) @(posedge clk);
    arst_n <= 1'b1;
    clken  <= 1'b1;

    check_reset_state();
    fill_and_stream();
    narrow_read_window();
    stall_during_read(60);
    random_read_enable(120);
    write_wrap_overwrite();

    // words still in flight settle in the FIFO, the oldest one on the head.
    test_name = "drain";
    repeat (LATENCY + 2) @(posedge clk);
    @(negedge clk);
    check_equal(test_name, 32'(exp_q[0]), 32'(m_data));
    $display("Done: no errors");
    $finish;
  end

endmodule
